// File: rtl/xbar_pkg.sv
// Crossbar package
// Sizes, fixed address map, connectivity matrix, opcode and response
// encodings, and the request and response payload structs
package xbar_pkg;

  // Port counts
  localparam int unsigned NUM_INI   = 2;
  localparam int unsigned NUM_TGT   = 2;

  // Payload widths
  localparam int unsigned ADDR_W    = 16;
  localparam int unsigned DATA_W    = 32;

  // Target side ID carries the source index on top
  localparam int unsigned INI_ID_W  = 2;
  localparam int unsigned TGT_ID_W  = INI_ID_W + 1;
  localparam int unsigned TGT_IDX_W = 1;

  // Outstanding limit per initiator demux
  localparam int unsigned MAX_TRANS = 4;

  // Address map, one rule per target, end is exclusive
  // Anything at 0x8000 and above hits no rule
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] RULE_START = {
    16'h4000,
    16'h0000
  };
  localparam logic [NUM_TGT-1:0][ADDR_W-1:0] RULE_END = {
    16'h8000,
    16'h4000
  };

  // Row per initiator, bit per target
  // Initiator 1 has no path to target 0
  localparam logic [NUM_INI-1:0][NUM_TGT-1:0] CONNECTIVITY = {
    2'b10,
    2'b11
  };

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } op_e;

  // Same codes as the AXI RESP field
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // Request as seen at an initiator port
  typedef struct packed {
    op_e                 op;
    logic [INI_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } ini_req_t;

  // Request at a target port, ID extended by the source index
  typedef struct packed {
    op_e                 op;
    logic [TGT_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } tgt_req_t;

  typedef struct packed {
    logic [INI_ID_W-1:0] id;
    logic [DATA_W-1:0]   rdata;
    resp_e               resp;
  } ini_rsp_t;

  typedef struct packed {
    logic [TGT_ID_W-1:0] id;
    logic [DATA_W-1:0]   rdata;
    resp_e               resp;
  } tgt_rsp_t;

endpackage

// File: rtl/addr_decoder.sv
// Address decoder
// Looks the request address up in the fixed map, applies the default
// target and flags a decode error for unmapped or blocked routes
`timescale 1ns/10ps

module addr_decoder #(
  parameter int unsigned ini_idx = 0
) (
  input  logic [xbar_pkg::ADDR_W-1:0]    addr_i,
  input  logic                           dflt_en_i,
  input  logic [xbar_pkg::TGT_IDX_W-1:0] dflt_idx_i,
  output logic [xbar_pkg::TGT_IDX_W-1:0] tgt_idx_o,
  output logic                           dec_err_o
);

  typedef logic [xbar_pkg::TGT_IDX_W-1:0] idx_t;

  logic match;
  idx_t match_idx;
  idx_t sel_idx;

  // First rule that contains the address wins
  always_comb begin
    match     = 1'b0;
    match_idx = '0;
    for (int t = 0; t < xbar_pkg::NUM_TGT; t++) begin
      if (!match &&
          (addr_i >= xbar_pkg::RULE_START[t]) &&
          (addr_i <  xbar_pkg::RULE_END[t])) begin
        match     = 1'b1;
        match_idx = idx_t'(t);
      end
    end
  end

  // Fall back to the default target when nothing matched
  assign sel_idx = match ? match_idx : dflt_idx_i;

  always_comb begin
    dec_err_o = 1'b0;
    // Unmapped and no default
    if (!match && !dflt_en_i) begin
      dec_err_o = 1'b1;
    end
    // Route exists but this initiator may not use it
    if (!xbar_pkg::CONNECTIVITY[ini_idx][sel_idx]) begin
      dec_err_o = 1'b1;
    end
  end

  assign tgt_idx_o = sel_idx;

endmodule

// File: rtl/decerr_responder.sv
// Decode error responder
// Accepts one unroutable request at a time and answers it with DECERR,
// zero read data and the request ID
`timescale 1ns/10ps

module decerr_responder (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  xbar_pkg::ini_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output xbar_pkg::ini_rsp_t rsp_o,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i
);

  logic                            busy_q;
  logic [xbar_pkg::INI_ID_W-1:0]   id_q;

  // Only take a new request when the last answer has left
  assign req_ready_o = !busy_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (req_valid_i && req_ready_o) begin
      busy_q <= 1'b1;
    end else if (rsp_valid_o && rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Capture the ID on acceptance
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      id_q <= req_i.id;
    end
  end

  // Answer is up the cycle after acceptance, held until taken
  assign rsp_valid_o = busy_q;

  always_comb begin
    rsp_o       = '0;
    rsp_o.id    = id_q;
    rsp_o.rdata = '0;
    rsp_o.resp  = xbar_pkg::RESP_DECERR;
  end

endmodule

// File: rtl/port_demux.sv
// Initiator port demux
// Routes each request to one target or to the local error responder and
// merges the responses back, keeping one destination in flight at a time
`timescale 1ns/10ps

module port_demux #(
  parameter int unsigned ini_idx = 0
) (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  xbar_pkg::ini_req_t                           ini_req_i,
  input  logic                                         ini_req_valid_i,
  output logic                                         ini_req_ready_o,
  output xbar_pkg::ini_rsp_t                           ini_rsp_o,
  output logic                                         ini_rsp_valid_o,
  input  logic                                         ini_rsp_ready_i,
  input  logic                                         dflt_en_i,
  input  logic [xbar_pkg::TGT_IDX_W-1:0]               dflt_idx_i,
  output xbar_pkg::ini_req_t                           tgt_req_o,
  output logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_req_ready_i,
  input  xbar_pkg::ini_rsp_t [xbar_pkg::NUM_TGT-1:0]   tgt_rsp_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                 tgt_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT-1:0]                 tgt_rsp_ready_o
);

  // Destinations are the targets plus the error responder on top
  typedef logic [$clog2(xbar_pkg::NUM_TGT+1)-1:0] dest_t;
  typedef logic [$clog2(xbar_pkg::MAX_TRANS+1)-1:0] cnt_t;

  localparam dest_t ERR_DEST = dest_t'(xbar_pkg::NUM_TGT);

  logic [xbar_pkg::TGT_IDX_W-1:0] dec_idx;
  logic [xbar_pkg::TGT_IDX_W-1:0] cur_idx;
  logic                           dec_err;
  dest_t                          sel_dest;
  dest_t                          cur_dest_q;
  cnt_t                           cnt_q;
  logic                           stall;
  logic                           req_hs;
  logic                           rsp_hs;

  logic                           err_req_valid;
  logic                           err_req_ready;
  xbar_pkg::ini_rsp_t             err_rsp;
  logic                           err_rsp_valid;
  logic                           err_rsp_ready;

  addr_decoder #(
    .ini_idx ( ini_idx )
  ) addr_decoder_i (
    .addr_i     ( ini_req_i.addr ),
    .dflt_en_i  ( dflt_en_i      ),
    .dflt_idx_i ( dflt_idx_i     ),
    .tgt_idx_o  ( dec_idx        ),
    .dec_err_o  ( dec_err        )
  );

  decerr_responder decerr_responder_i (
    .clk_i       ( clk_i         ),
    .rst_n_i     ( rst_n_i       ),
    .req_i       ( ini_req_i     ),
    .req_valid_i ( err_req_valid ),
    .req_ready_o ( err_req_ready ),
    .rsp_o       ( err_rsp       ),
    .rsp_valid_o ( err_rsp_valid ),
    .rsp_ready_i ( err_rsp_ready )
  );

  assign sel_dest = dec_err ? ERR_DEST : dest_t'(dec_idx);

  // Hold off a switch of destination while anything is in flight,
  // otherwise responses could overtake each other
  assign stall = ((cnt_q != '0) && (sel_dest != cur_dest_q)) ||
                 (cnt_q == cnt_t'(xbar_pkg::MAX_TRANS));

  // Payload goes to every target, only the valid is steered
  assign tgt_req_o = ini_req_i;

  always_comb begin
    tgt_req_valid_o = '0;
    err_req_valid   = 1'b0;
    ini_req_ready_o = 1'b0;
    if (ini_req_valid_i && !stall) begin
      if (sel_dest == ERR_DEST) begin
        err_req_valid   = 1'b1;
        ini_req_ready_o = err_req_ready;
      end else begin
        tgt_req_valid_o[dec_idx] = 1'b1;
        ini_req_ready_o          = tgt_req_ready_i[dec_idx];
      end
    end
  end

  // Responses can only come from the current destination
  assign cur_idx = cur_dest_q[xbar_pkg::TGT_IDX_W-1:0];

  always_comb begin
    ini_rsp_o       = err_rsp;
    ini_rsp_valid_o = 1'b0;
    tgt_rsp_ready_o = '0;
    err_rsp_ready   = 1'b0;
    if (cur_dest_q == ERR_DEST) begin
      ini_rsp_valid_o = err_rsp_valid;
      err_rsp_ready   = ini_rsp_ready_i;
    end else begin
      ini_rsp_o                = tgt_rsp_i[cur_idx];
      ini_rsp_valid_o          = tgt_rsp_valid_i[cur_idx];
      tgt_rsp_ready_o[cur_idx] = ini_rsp_ready_i;
    end
  end

  assign req_hs = ini_req_valid_i && ini_req_ready_o;
  assign rsp_hs = ini_rsp_valid_o && ini_rsp_ready_i;

  // Outstanding count and destination of the open transactions
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q      <= '0;
      cur_dest_q <= '0;
    end else begin
      if (req_hs) begin
        cur_dest_q <= sel_dest;
      end
      if (req_hs && !rsp_hs) begin
        cnt_q <= cnt_q + cnt_t'(1);
      end else if (rsp_hs && !req_hs) begin
        cnt_q <= cnt_q - cnt_t'(1);
      end
    end
  end

endmodule

// File: rtl/target_mux.sv
// Target port mux
// Round-robin arbitration between the initiator demuxes with a grant lock,
// ID extension by the source index and response steering by that index
`timescale 1ns/10ps

module target_mux (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  input  xbar_pkg::ini_req_t [xbar_pkg::NUM_INI-1:0] ini_req_i,
  input  logic [xbar_pkg::NUM_INI-1:0]               ini_req_valid_i,
  output logic [xbar_pkg::NUM_INI-1:0]               ini_req_ready_o,
  output xbar_pkg::ini_rsp_t                         ini_rsp_o,
  output logic [xbar_pkg::NUM_INI-1:0]               ini_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INI-1:0]               ini_rsp_ready_i,
  output xbar_pkg::tgt_req_t                         tgt_req_o,
  output logic                                       tgt_req_valid_o,
  input  logic                                       tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t                         tgt_rsp_i,
  input  logic                                       tgt_rsp_valid_i,
  output logic                                       tgt_rsp_ready_o
);

  // Source index lives in the ID bits above the initiator ID
  typedef logic [xbar_pkg::TGT_ID_W-xbar_pkg::INI_ID_W-1:0] src_t;

  src_t rr_q;
  src_t gnt_q;
  logic lock_q;
  src_t pick;
  src_t gnt;
  src_t rsp_src;

  // Search from the pointer upward for the first requester
  always_comb begin : arb_comb
    logic found;
    src_t cand;
    found = 1'b0;
    pick  = rr_q;
    for (int k = 0; k < xbar_pkg::NUM_INI; k++) begin
      cand = src_t'((int'(rr_q) + k) % xbar_pkg::NUM_INI);
      if (!found && ini_req_valid_i[cand]) begin
        found = 1'b1;
        pick  = cand;
      end
    end
  end

  // Keep the grant while the target has not taken the request
  assign gnt = lock_q ? gnt_q : pick;

  assign tgt_req_valid_o = ini_req_valid_i[gnt];

  always_comb begin
    tgt_req_o       = '0;
    tgt_req_o.op    = ini_req_i[gnt].op;
    tgt_req_o.id    = {gnt, ini_req_i[gnt].id};
    tgt_req_o.addr  = ini_req_i[gnt].addr;
    tgt_req_o.wdata = ini_req_i[gnt].wdata;
  end

  always_comb begin
    ini_req_ready_o      = '0;
    ini_req_ready_o[gnt] = tgt_req_ready_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q   <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= tgt_req_valid_o && !tgt_req_ready_i;
      if (tgt_req_valid_o) begin
        gnt_q <= gnt;
      end
      // Winner goes to the back of the queue
      if (tgt_req_valid_o && tgt_req_ready_i) begin
        rr_q <= src_t'((int'(gnt) + 1) % xbar_pkg::NUM_INI);
      end
    end
  end

  // Response goes back by the source bits, which are stripped here
  assign rsp_src = tgt_rsp_i.id[xbar_pkg::TGT_ID_W-1:xbar_pkg::INI_ID_W];

  always_comb begin
    ini_rsp_o       = '0;
    ini_rsp_o.id    = tgt_rsp_i.id[xbar_pkg::INI_ID_W-1:0];
    ini_rsp_o.rdata = tgt_rsp_i.rdata;
    ini_rsp_o.resp  = tgt_rsp_i.resp;
  end

  always_comb begin
    ini_rsp_valid_o          = '0;
    ini_rsp_valid_o[rsp_src] = tgt_rsp_valid_i;
  end

  assign tgt_rsp_ready_o = ini_rsp_ready_i[rsp_src];

endmodule

// File: rtl/xbar_top.sv
// Crossbar top level
// One demux per initiator port and one mux per target port,
// cross-wired so that every demux output reaches every mux
`timescale 1ns/10ps

module xbar_top (
  input  logic                                                  clk_i,
  input  logic                                                  rst_n_i,
  input  xbar_pkg::ini_req_t [xbar_pkg::NUM_INI-1:0]            ini_req_i,
  input  logic [xbar_pkg::NUM_INI-1:0]                          ini_req_valid_i,
  output logic [xbar_pkg::NUM_INI-1:0]                          ini_req_ready_o,
  output xbar_pkg::ini_rsp_t [xbar_pkg::NUM_INI-1:0]            ini_rsp_o,
  output logic [xbar_pkg::NUM_INI-1:0]                          ini_rsp_valid_o,
  input  logic [xbar_pkg::NUM_INI-1:0]                          ini_rsp_ready_i,
  input  logic [xbar_pkg::NUM_INI-1:0]                          dflt_en_i,
  input  logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::TGT_IDX_W-1:0] dflt_idx_i,
  output xbar_pkg::tgt_req_t [xbar_pkg::NUM_TGT-1:0]            tgt_req_o,
  output logic [xbar_pkg::NUM_TGT-1:0]                          tgt_req_valid_o,
  input  logic [xbar_pkg::NUM_TGT-1:0]                          tgt_req_ready_i,
  input  xbar_pkg::tgt_rsp_t [xbar_pkg::NUM_TGT-1:0]            tgt_rsp_i,
  input  logic [xbar_pkg::NUM_TGT-1:0]                          tgt_rsp_valid_i,
  output logic [xbar_pkg::NUM_TGT-1:0]                          tgt_rsp_ready_o
);

  // Demux side, indexed [initiator][target]
  xbar_pkg::ini_req_t [xbar_pkg::NUM_INI-1:0]                        dmx_req;
  logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::NUM_TGT-1:0]               dmx_req_valid;
  logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::NUM_TGT-1:0]               dmx_req_ready;
  xbar_pkg::ini_rsp_t [xbar_pkg::NUM_INI-1:0][xbar_pkg::NUM_TGT-1:0] dmx_rsp;
  logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::NUM_TGT-1:0]               dmx_rsp_valid;
  logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::NUM_TGT-1:0]               dmx_rsp_ready;

  // Mux side, indexed [target][initiator]
  xbar_pkg::ini_req_t [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INI-1:0] mux_req;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INI-1:0]               mux_req_valid;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INI-1:0]               mux_req_ready;
  xbar_pkg::ini_rsp_t [xbar_pkg::NUM_TGT-1:0]                        mux_rsp;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INI-1:0]               mux_rsp_valid;
  logic [xbar_pkg::NUM_TGT-1:0][xbar_pkg::NUM_INI-1:0]               mux_rsp_ready;

  for (genvar i = 0; i < xbar_pkg::NUM_INI; i++) begin : gen_demux
    port_demux #(
      .ini_idx ( i )
    ) port_demux_i (
      .clk_i           ( clk_i              ),
      .rst_n_i         ( rst_n_i            ),
      .ini_req_i       ( ini_req_i[i]       ),
      .ini_req_valid_i ( ini_req_valid_i[i] ),
      .ini_req_ready_o ( ini_req_ready_o[i] ),
      .ini_rsp_o       ( ini_rsp_o[i]       ),
      .ini_rsp_valid_o ( ini_rsp_valid_o[i] ),
      .ini_rsp_ready_i ( ini_rsp_ready_i[i] ),
      .dflt_en_i       ( dflt_en_i[i]       ),
      .dflt_idx_i      ( dflt_idx_i[i]      ),
      .tgt_req_o       ( dmx_req[i]         ),
      .tgt_req_valid_o ( dmx_req_valid[i]   ),
      .tgt_req_ready_i ( dmx_req_ready[i]   ),
      .tgt_rsp_i       ( dmx_rsp[i]         ),
      .tgt_rsp_valid_i ( dmx_rsp_valid[i]   ),
      .tgt_rsp_ready_o ( dmx_rsp_ready[i]   )
    );
  end

  // Transpose between demux and mux indexing
  for (genvar i = 0; i < xbar_pkg::NUM_INI; i++) begin : gen_cross_ini
    for (genvar j = 0; j < xbar_pkg::NUM_TGT; j++) begin : gen_cross_tgt
      assign mux_req[j][i]       = dmx_req[i];
      assign mux_req_valid[j][i] = dmx_req_valid[i][j];
      assign dmx_req_ready[i][j] = mux_req_ready[j][i];
      assign dmx_rsp[i][j]       = mux_rsp[j];
      assign dmx_rsp_valid[i][j] = mux_rsp_valid[j][i];
      assign mux_rsp_ready[j][i] = dmx_rsp_ready[i][j];
    end
  end

  for (genvar j = 0; j < xbar_pkg::NUM_TGT; j++) begin : gen_mux
    target_mux target_mux_i (
      .clk_i           ( clk_i              ),
      .rst_n_i         ( rst_n_i            ),
      .ini_req_i       ( mux_req[j]         ),
      .ini_req_valid_i ( mux_req_valid[j]   ),
      .ini_req_ready_o ( mux_req_ready[j]   ),
      .ini_rsp_o       ( mux_rsp[j]         ),
      .ini_rsp_valid_o ( mux_rsp_valid[j]   ),
      .ini_rsp_ready_i ( mux_rsp_ready[j]   ),
      .tgt_req_o       ( tgt_req_o[j]       ),
      .tgt_req_valid_o ( tgt_req_valid_o[j] ),
      .tgt_req_ready_i ( tgt_req_ready_i[j] ),
      .tgt_rsp_i       ( tgt_rsp_i[j]       ),
      .tgt_rsp_valid_i ( tgt_rsp_valid_i[j] ),
      .tgt_rsp_ready_o ( tgt_rsp_ready_o[j] )
    );
  end

endmodule

// File: tb/xbar_checker.sv
// Crossbar protocol checker
// Bound to the crossbar top, watches valid/ready hold and payload stability
// at every port, default-route stability and quiet target ports in reset
`timescale 1ns/10ps

module xbar_checker (
  input logic                                                  clk_i,
  input logic                                                  rst_n_i,
  input xbar_pkg::ini_req_t [xbar_pkg::NUM_INI-1:0]            ini_req_i,
  input logic [xbar_pkg::NUM_INI-1:0]                          ini_req_valid_i,
  input logic [xbar_pkg::NUM_INI-1:0]                          ini_req_ready_o,
  input xbar_pkg::ini_rsp_t [xbar_pkg::NUM_INI-1:0]            ini_rsp_o,
  input logic [xbar_pkg::NUM_INI-1:0]                          ini_rsp_valid_o,
  input logic [xbar_pkg::NUM_INI-1:0]                          ini_rsp_ready_i,
  input logic [xbar_pkg::NUM_INI-1:0]                          dflt_en_i,
  input logic [xbar_pkg::NUM_INI-1:0][xbar_pkg::TGT_IDX_W-1:0] dflt_idx_i,
  input xbar_pkg::tgt_req_t [xbar_pkg::NUM_TGT-1:0]            tgt_req_o,
  input logic [xbar_pkg::NUM_TGT-1:0]                          tgt_req_valid_o,
  input logic [xbar_pkg::NUM_TGT-1:0]                          tgt_req_ready_i,
  input xbar_pkg::tgt_rsp_t [xbar_pkg::NUM_TGT-1:0]            tgt_rsp_i,
  input logic [xbar_pkg::NUM_TGT-1:0]                          tgt_rsp_valid_i,
  input logic [xbar_pkg::NUM_TGT-1:0]                          tgt_rsp_ready_o
);

  for (genvar i = 0; i < xbar_pkg::NUM_INI; i++) begin : gen_ini
    // Pending request keeps valid and payload
    ini_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ini_req_valid_i[i] && !ini_req_ready_o[i] |=>
        ini_req_valid_i[i] && $stable(ini_req_i[i]))
      else $error("initiator %0d request dropped or changed while pending", i);

    ini_rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ini_rsp_valid_o[i] && !ini_rsp_ready_i[i] |=>
        ini_rsp_valid_o[i] && $stable(ini_rsp_o[i]))
      else $error("initiator %0d response dropped or changed while pending", i);

    // Route selection must not move under a waiting request
    dflt_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ini_req_valid_i[i] && !ini_req_ready_o[i] |=>
        $stable(dflt_en_i[i]) && $stable(dflt_idx_i[i]))
      else $error("initiator %0d default route changed while pending", i);
  end

  for (genvar t = 0; t < xbar_pkg::NUM_TGT; t++) begin : gen_tgt
    tgt_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_req_valid_o[t] && !tgt_req_ready_i[t] |=>
        tgt_req_valid_o[t] && $stable(tgt_req_o[t]))
      else $error("target %0d request dropped or changed while pending", t);

    tgt_rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tgt_rsp_valid_i[t] && !tgt_rsp_ready_o[t] |=>
        tgt_rsp_valid_i[t] && $stable(tgt_rsp_i[t]))
      else $error("target %0d response dropped or changed while pending", t);

    // Nothing leaves toward a target during reset
    rst_quiet_a: assert property (@(posedge clk_i)
      !rst_n_i |-> !tgt_req_valid_o[t])
      else $error("target %0d request valid during reset", t);
  end

endmodule

bind xbar_top xbar_checker xbar_checker_i (
  .clk_i           ( clk_i           ),
  .rst_n_i         ( rst_n_i         ),
  .ini_req_i       ( ini_req_i       ),
  .ini_req_valid_i ( ini_req_valid_i ),
  .ini_req_ready_o ( ini_req_ready_o ),
  .ini_rsp_o       ( ini_rsp_o       ),
  .ini_rsp_valid_o ( ini_rsp_valid_o ),
  .ini_rsp_ready_i ( ini_rsp_ready_i ),
  .dflt_en_i       ( dflt_en_i       ),
  .dflt_idx_i      ( dflt_idx_i      ),
  .tgt_req_o       ( tgt_req_o       ),
  .tgt_req_valid_o ( tgt_req_valid_o ),
  .tgt_req_ready_i ( tgt_req_ready_i ),
  .tgt_rsp_i       ( tgt_rsp_i       ),
  .tgt_rsp_valid_i ( tgt_rsp_valid_i ),
  .tgt_rsp_ready_o ( tgt_rsp_ready_o )
);

// File: tb/xbar_tb.sv
// Crossbar testbench
// Drives both initiator ports, models both targets with memories, predicts
// every response from the address map and compares in per-initiator order
`timescale 1ns/10ps

module xbar_tb;

  localparam int N_P1    = 32;
  localparam int N_P2    = 8;
  localparam int N_P3    = 8;
  localparam int N_P4    = 6;
  localparam int N_RAND  = 60;
  localparam int N_TOTAL = N_P1 + N_P2 + N_P3 + N_P4 + 2 * N_RAND;
  // Generous per-request budget covers random gaps and back-pressure
  localparam int CYC_LIMIT = 40 * N_TOTAL;

  logic clk_i;
  logic rst_n_i;

  xbar_pkg::ini_req_t [1:0] ini_req;
  logic [1:0]               ini_req_valid;
  logic [1:0]               ini_req_ready;
  xbar_pkg::ini_rsp_t [1:0] ini_rsp;
  logic [1:0]               ini_rsp_valid;
  logic [1:0]               ini_rsp_ready;
  logic [1:0]               dflt_en;
  logic [1:0][0:0]          dflt_idx;
  xbar_pkg::tgt_req_t [1:0] tgt_req;
  logic [1:0]               tgt_req_valid;
  logic [1:0]               tgt_req_ready;
  xbar_pkg::tgt_rsp_t [1:0] tgt_rsp;
  logic [1:0]               tgt_rsp_valid;
  logic [1:0]               tgt_rsp_ready;

  // Stimulus, expectations and target model state
  xbar_pkg::ini_req_t stim_q[2][$];
  xbar_pkg::ini_rsp_t exp_q[2][$];
  int                 exp_cyc[2][$];
  xbar_pkg::tgt_req_t tq[4][$];
  xbar_pkg::tgt_rsp_t mq[2][$];
  logic [31:0]        mem[2][256];
  logic [31:0]        shadow[2][256];
  logic [1:0]         seen;
  logic [31:0]        drv_seed;
  logic [31:0]        stim_seed;
  int                 cyc;

  xbar_top dut_i (
    .clk_i           ( clk_i         ),
    .rst_n_i         ( rst_n_i       ),
    .ini_req_i       ( ini_req       ),
    .ini_req_valid_i ( ini_req_valid ),
    .ini_req_ready_o ( ini_req_ready ),
    .ini_rsp_o       ( ini_rsp       ),
    .ini_rsp_valid_o ( ini_rsp_valid ),
    .ini_rsp_ready_i ( ini_rsp_ready ),
    .dflt_en_i       ( dflt_en       ),
    .dflt_idx_i      ( dflt_idx      ),
    .tgt_req_o       ( tgt_req       ),
    .tgt_req_valid_o ( tgt_req_valid ),
    .tgt_req_ready_i ( tgt_req_ready ),
    .tgt_rsp_i       ( tgt_rsp       ),
    .tgt_rsp_valid_i ( tgt_rsp_valid ),
    .tgt_rsp_ready_o ( tgt_rsp_ready )
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Fill pattern covers target and full word index
  function automatic logic [31:0] fill_word(input int t, input int idx);
    return {8'ha5, 7'd0, t[0], ~idx[7:0], idx[7:0]};
  endfunction

  // Map rules with 0x0000 and 0x4000 windows, default above and no path 1 to 0
  function automatic logic route_of(input int ini, input logic [15:0] addr,
                                    input logic en, input logic idx, output int tgt);
    tgt = -1;
    if (addr < 16'h4000) begin
      tgt = 0;
    end else if (addr < 16'h8000) begin
      tgt = 1;
    end else if (en) begin
      tgt = int'(idx);
    end
    return (tgt >= 0) && !(ini == 1 && tgt == 0);
  endfunction

  function automatic xbar_pkg::ini_rsp_t predict_rsp(input int ini, input xbar_pkg::ini_req_t req,
                                                     input logic en, input logic idx);
    xbar_pkg::ini_rsp_t rsp;
    int                 t;
    rsp.id    = req.id;
    rsp.rdata = '0;
    rsp.resp  = xbar_pkg::RESP_DECERR;
    if (route_of(ini, req.addr, en, idx, t)) begin
      rsp.resp = xbar_pkg::RESP_OKAY;
      if (req.op == xbar_pkg::OP_WRITE) begin
        shadow[t][req.addr[9:2]] = req.wdata;
      end else begin
        rsp.rdata = shadow[t][req.addr[9:2]];
      end
    end
    return rsp;
  endfunction

  task automatic stop_on_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first failure");
  endtask

  task automatic check_ini_rsp(input string sig, input xbar_pkg::ini_rsp_t exp,
                               input xbar_pkg::ini_rsp_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h got %h", $time, sig, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic check_tgt_req(input string sig, input xbar_pkg::tgt_req_t exp,
                               input xbar_pkg::tgt_req_t act);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %h got %h", $time, sig, exp, act);
      stop_on_failure();
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Initiator drivers and target models
  always @(posedge clk_i) begin
    xbar_pkg::tgt_rsp_t rsp;
    drv_seed = xorshift(drv_seed);
    for (int i = 0; i < 2; i++) begin
      if (!ini_req_valid[i] || ini_req_ready[i]) begin
        if (rst_n_i && stim_q[i].size() > 0 && drv_seed[2*i+1 -: 2] != 2'd0) begin
          ini_req[i]       <= stim_q[i].pop_front();
          ini_req_valid[i] <= 1'b1;
        end else begin
          ini_req_valid[i] <= 1'b0;
        end
      end
      ini_rsp_ready[i] <= drv_seed[4+2*i] | drv_seed[5+2*i];
    end
    for (int t = 0; t < 2; t++) begin
      if (tgt_req_valid[t] && tgt_req_ready[t]) begin
        rsp.id    = tgt_req[t].id;
        rsp.resp  = xbar_pkg::RESP_OKAY;
        rsp.rdata = '0;
        if (tgt_req[t].op == xbar_pkg::OP_WRITE) begin
          mem[t][tgt_req[t].addr[9:2]] = tgt_req[t].wdata;
        end else begin
          rsp.rdata = mem[t][tgt_req[t].addr[9:2]];
        end
        mq[t].push_back(rsp);
      end
      tgt_req_ready[t] <= drv_seed[8+t] | drv_seed[10+t];
      if (!tgt_rsp_valid[t] || tgt_rsp_ready[t]) begin
        if (mq[t].size() > 0 && drv_seed[12+t]) begin
          tgt_rsp[t]       <= mq[t].pop_front();
          tgt_rsp_valid[t] <= 1'b1;
        end else begin
          tgt_rsp_valid[t] <= 1'b0;
        end
      end
    end
  end

  // Compare process, all values sampled before the edge
  always @(posedge clk_i) begin
    xbar_pkg::tgt_req_t ex;
    int                 t;
    int                 src;
    if (rst_n_i) begin
      for (int i = 0; i < 2; i++) begin
        if (ini_req_valid[i] && ini_req_ready[i]) begin
          exp_q[i].push_back(predict_rsp(i, ini_req[i], dflt_en[i], dflt_idx[i]));
          exp_cyc[i].push_back(cyc);
          if (route_of(i, ini_req[i].addr, dflt_en[i], dflt_idx[i], t)) begin
            ex.op    = ini_req[i].op;
            ex.id    = {i[0], ini_req[i].id};
            ex.addr  = ini_req[i].addr;
            ex.wdata = ini_req[i].wdata;
            tq[i*2+t].push_back(ex);
          end
        end
        if (ini_rsp_valid[i]) begin
          if (exp_q[i].size() == 0) begin
            $display("Error: initiator %0d got a response with nothing outstanding", i);
            stop_on_failure();
          end
          // Error answers must show up the cycle after the handshake
          if (exp_q[i][0].resp == xbar_pkg::RESP_DECERR && !seen[i] &&
              cyc != exp_cyc[i][0] + 1) begin
            $display("Error: decode error response on initiator %0d not one cycle late", i);
            stop_on_failure();
          end
          seen[i] = 1'b1;
          if (ini_rsp_ready[i]) begin
            check_ini_rsp($sformatf("ini_rsp_o[%0d]", i), exp_q[i].pop_front(), ini_rsp[i]);
            void'(exp_cyc[i].pop_front());
            seen[i] = 1'b0;
          end
        end
      end
      for (int k = 0; k < 2; k++) begin
        if (tgt_req_valid[k] && tgt_req_ready[k]) begin
          src = int'(tgt_req[k].id[2]);
          if (tq[src*2+k].size() == 0) begin
            $display("Error: target %0d got a request that should not be there", k);
            stop_on_failure();
          end
          check_tgt_req($sformatf("tgt_req_o[%0d]", k), tq[src*2+k].pop_front(), tgt_req[k]);
        end
      end
    end
    if (cyc > CYC_LIMIT) begin
      $display("Error: run did not finish within %0d cycles", CYC_LIMIT);
      stop_on_failure();
    end
    cyc++;
  end

  task automatic queue_req(input int i, input xbar_pkg::op_e op, input logic [15:0] addr);
    xbar_pkg::ini_req_t r;
    stim_seed = xorshift(stim_seed);
    r.op    = op;
    r.id    = stim_seed[1:0];
    r.addr  = addr;
    r.wdata = xorshift(stim_seed ^ 32'h1234_5678);
    stim_q[i].push_back(r);
  endtask

  // Idle means nothing queued, nothing presented and nothing expected
  task automatic wait_idle();
    do begin
      @(posedge clk_i);
    end while (stim_q[0].size() + stim_q[1].size() + exp_q[0].size() + exp_q[1].size() != 0 ||
               ini_req_valid != 2'b00);
  endtask

  task automatic set_dflt(input logic [1:0] en, input logic i0, input logic i1);
    @(posedge clk_i);
    dflt_en     <= en;
    dflt_idx[0] <= i0;
    dflt_idx[1] <= i1;
  endtask

  function automatic logic [15:0] word_addr(input logic [15:0] base, input int i, input int k);
    return base | 16'(i << 9) | 16'((k & 127) << 2);
  endfunction

  initial begin
    logic [15:0] bases[3];
    bases = '{16'h0000, 16'h4000, 16'h8000};
    stim_seed = 32'h79e9cda0;
    drv_seed  = 32'h79e9cda0 ^ 32'h5555_aaaa;
    rst_n_i = 1'b0;
    ini_req = '0;
    ini_req_valid = '0;
    ini_rsp_ready = '0;
    dflt_en = '0;
    dflt_idx = '0;
    tgt_req_ready = '0;
    tgt_rsp = '0;
    tgt_rsp_valid = '0;
    seen = '0;
    cyc = 0;
    for (int t = 0; t < 2; t++) begin
      for (int w = 0; w < 256; w++) begin
        mem[t][w]    = fill_word(t, w);
        shadow[t][w] = fill_word(t, w);
      end
    end
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Mapped writes then reads from both initiators
    for (int k = 0; k < 8; k++) begin
      queue_req(0, xbar_pkg::OP_WRITE, word_addr(k < 4 ? 16'h0000 : 16'h4000, 0, k));
      queue_req(1, xbar_pkg::OP_WRITE, word_addr(16'h4000, 1, k));
    end
    for (int k = 0; k < 8; k++) begin
      queue_req(0, xbar_pkg::OP_READ, word_addr(k < 4 ? 16'h0000 : 16'h4000, 0, k));
      queue_req(1, xbar_pkg::OP_READ, word_addr(16'h4000, 1, k));
    end
    wait_idle();

    // Unmapped with no default
    for (int k = 0; k < 4; k++) begin
      queue_req(0, xbar_pkg::op_e'(k[0]), word_addr(16'h8000, 0, k));
      queue_req(1, xbar_pkg::op_e'(k[0]), word_addr(16'hc000, 1, k));
    end
    wait_idle();

    // Unmapped routed to the default target 1
    set_dflt(2'b11, 1'b1, 1'b1);
    for (int k = 0; k < 4; k++) begin
      queue_req(0, k < 2 ? xbar_pkg::OP_WRITE : xbar_pkg::OP_READ,
                word_addr(16'h9000, 0, 20 + k % 2));
      queue_req(1, k < 2 ? xbar_pkg::OP_WRITE : xbar_pkg::OP_READ,
                word_addr(16'h9000, 1, 20 + k % 2));
    end
    wait_idle();

    // Initiator 1 toward target 0, direct and by default
    set_dflt(2'b11, 1'b0, 1'b0);
    queue_req(1, xbar_pkg::OP_WRITE, word_addr(16'h0000, 1, 3));
    queue_req(1, xbar_pkg::OP_READ, word_addr(16'h0000, 1, 3));
    queue_req(1, xbar_pkg::OP_WRITE, word_addr(16'h8000, 1, 3));
    queue_req(1, xbar_pkg::OP_READ, word_addr(16'h8000, 1, 3));
    queue_req(0, xbar_pkg::OP_WRITE, word_addr(16'ha000, 0, 9));
    queue_req(0, xbar_pkg::OP_READ, word_addr(16'ha000, 0, 9));
    wait_idle();

    // Random mix over all windows with back-pressure everywhere
    set_dflt(2'b01, 1'b0, 1'b0);
    for (int k = 0; k < N_RAND; k++) begin
      for (int i = 0; i < 2; i++) begin
        stim_seed = xorshift(stim_seed);
        queue_req(i, xbar_pkg::op_e'(stim_seed[0]),
                  word_addr(bases[stim_seed[9:8] % 3], i, int'(stim_seed[22:16])));
      end
    end
    wait_idle();
    repeat (4) @(posedge clk_i);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: compile.f
rtl/xbar_pkg.sv
rtl/addr_decoder.sv
rtl/decerr_responder.sv
rtl/port_demux.sv
rtl/target_mux.sv
rtl/xbar_top.sv
tb/xbar_checker.sv
tb/xbar_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the crossbar simulation with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module xbar_tb \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vxbar_tb > sim.log 2>&1
cat sim.log
grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && exit 1
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log || exit 1
exit 0
